//--- all.f
+incdir+test
verilog/hbm_pkg.sv
verilog/hbm_addr_router.sv
verilog/hbm_channel.sv
verilog/hbm_read_merge.sv
verilog/hbm_ram_top.sv
test/hbm_ram_tb.sv

//--- test/hbm_ram_tasks.svh
`ifndef HBM_RAM_TASKS_SVH
`define HBM_RAM_TASKS_SVH

  // even parity bit set when its byte holds an odd count of ones
  function automatic logic [STRB_W-1:0] byte_parity(input logic [DATA_W-1:0] word);
    logic [STRB_W-1:0] par;
    int                ones;
    for (int b = 0; b < STRB_W; b++) begin
      ones = 0;
      for (int k = 0; k < 8; k++) begin
        ones = ones + word[b*8 + k];
      end
      par[b] = ones[0];
    end
    return par;
  endfunction

  function automatic logic [DATA_W-1:0] random_word();
    logic [DATA_W-1:0] w;
    for (int i = 0; i < DATA_W/32; i++) begin
      w[i*32 +: 32] = lcg_next();
    end
    return w;
  endfunction

  // strobe held until the caller moves on and model updated lane by lane
  task automatic write_req(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= OP_WRITE;
    req_addr  <= addr;
    req_wdata <= data;
    req_wstrb <= strb;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        ref_mem[addr][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic read_req(input logic [ADDR_W-1:0] addr);
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= OP_READ;
    req_addr  <= addr;
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(ref_mem[addr]);
    exp_par_q.push_back(byte_parity(ref_mem[addr]));
    exp_cyc_q.push_back(cyc + 1 + READ_LATENCY);   // negedge after READ_LATENCY more edges
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // queues sampled at the rising edge while the monitor pops at the falling one
  task automatic drain_reads();
    int waited;
    waited = 0;
    while (exp_cyc_q.size() != 0 && waited < READ_LATENCY + 4) begin
      @(posedge clk);
      waited++;
    end
    if (exp_cyc_q.size() != 0) begin
      $display("no read response for addr %0h, %0d reads lost", exp_addr_q[0], exp_cyc_q.size());
      errors++;
      exp_cyc_q.delete();
      exp_addr_q.delete();
      exp_data_q.delete();
      exp_par_q.delete();
    end
  endtask

  task automatic compare_response();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] exp_data;
    logic [STRB_W-1:0] exp_par;
    int                exp_cyc;
    addr     = exp_addr_q.pop_front();
    exp_data = exp_data_q.pop_front();
    exp_par  = exp_par_q.pop_front();
    exp_cyc  = exp_cyc_q.pop_front();
    if (cyc != exp_cyc) begin
      $display("mismatch rd_valid cycle addr %0h: got %0h expected %0h", addr, cyc, exp_cyc);
      errors++;
    end
    if (rd_data !== exp_data) begin
      $display("mismatch rd_data addr %0h: got %h expected %h", addr, rd_data, exp_data);
      errors++;
    end
    if (rd_parity !== exp_par) begin
      $display("mismatch rd_parity addr %0h: got %h expected %h", addr, rd_parity, exp_par);
      errors++;
    end
  endtask

  task automatic expect_zero(input string name, input logic [63:0] got);
    if (got !== '0) begin
      $display("mismatch %s: got %h expected 0", name, got);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  // write before the sweep ends is dropped and every word then reads back zero
  task automatic init_sweep();
    int err_before;
    int waited;
    err_before = errors;
    @(negedge clk);
    expect_zero("rd_valid", rd_valid);
    expect_zero("init_complete", init_complete);
    expect_zero("chan_valid", u_hbm_ram_top.chan_valid);
    expect_zero("ch_rd_valid", u_hbm_ram_top.ch_rd_valid);
    @(posedge clk);
    req_valid <= 1'b1;                             // not in the model so it must be ignored
    req_op    <= OP_WRITE;
    req_addr  <= ADDR_W'(5);
    req_wdata <= random_word();
    req_wstrb <= '1;
    @(posedge clk);
    req_valid <= 1'b0;
    waited = 0;
    while (init_complete !== 1'b1 && waited < ROWS + 16) begin
      @(negedge clk);
      waited++;
      if (init_complete !== 1'b1) begin
        expect_zero("chan_valid", u_hbm_ram_top.chan_valid);   // router holds requests off
      end
    end
    if (init_complete !== 1'b1) begin
      $display("init_complete never rose after reset");
      errors++;
    end
    for (int a = 0; a < NUM_ADDR; a++) begin
      read_req(ADDR_W'(a));
      idle_cycle();
    end
    drain_reads();
    report_test("init sweep", err_before);
  endtask

  task automatic full_word_writes();
    int err_before;
    err_before = errors;
    for (int a = 0; a < NUM_ADDR; a++) begin
      write_req(ADDR_W'(a), random_word(), '1);
      idle_cycle();
    end
    for (int a = 0; a < NUM_ADDR; a++) begin
      read_req(ADDR_W'(a));
      idle_cycle();
    end
    drain_reads();
    report_test("full writes", err_before);
  endtask

  task automatic byte_strobe_writes();
    int                err_before;
    logic [ADDR_W-1:0] addrs [N_STRB_WR];
    logic [31:0]       r;
    err_before = errors;
    for (int i = 0; i < N_STRB_WR; i++) begin
      r        = lcg_next();
      addrs[i] = r[ADDR_W+7:8];                    // skip the weak low bits
      write_req(addrs[i], random_word(), lcg_next());
      idle_cycle();
    end
    for (int i = 0; i < N_STRB_WR; i++) begin
      read_req(addrs[i]);
      idle_cycle();
    end
    drain_reads();
    report_test("byte strobes", err_before);
  endtask

  // one read per cycle and the monitor checks each pulse lands on its own cycle
  task automatic back_to_back_reads();
    int err_before;
    err_before = errors;
    for (int i = 0; i < N_B2B; i++) begin
      read_req(ADDR_W'(i * 5 + 3));                // walks across all channels
    end
    idle_cycle();
    drain_reads();
    report_test("back-to-back reads", err_before);
  endtask

  // same row in every channel with distinct tags read right after the last write
  task automatic channel_isolation();
    int                err_before;
    logic [DATA_W-1:0] w;
    logic [ROW_W-1:0]  row;
    err_before = errors;
    row = ROW_W'(lcg_next() >> 12);
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      w       = random_word();
      w[7:0]  = 8'(ch);                            // channel tag keeps the words distinct
      w[15:8] = 8'(row);
      write_req({CHAN_W'(ch), row}, w, '1);
    end
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      read_req({CHAN_W'(ch), row});
    end
    idle_cycle();
    drain_reads();
    report_test("channel isolation", err_before);
  endtask

`endif

//--- test/hbm_ram_tb.sv
`timescale 1ns/1ps

module hbm_ram_tb;
  import hbm_pkg::*;

  localparam int NUM_CHANNELS = 4;                 // must match CHAN_W
  localparam int ROWS         = 16;                // must match ROW_W
  localparam int CLK_PERIOD   = 100;               // ns
  localparam int NUM_ADDR     = 2**ADDR_W;         // every word behind the port
  localparam int N_STRB_WR    = 32;                // partial writes in the strobe test
  localparam int N_B2B        = 16;                // reads in the back-to-back burst
  // init write, init reads, full writes and reads, strobe test, burst, isolation
  localparam int N_REQ = 1 + NUM_ADDR + 2*NUM_ADDR + 2*N_STRB_WR + N_B2B + 4*NUM_CHANNELS;
  localparam int WATCHDOG_CYCLES = 4 + ROWS + 8 + N_REQ*(READ_LATENCY+2) + 64;

  logic              clk;
  logic              rst;
  logic              req_valid;
  op_e               req_op;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic [STRB_W-1:0] req_wstrb;
  logic              rd_valid;
  logic [DATA_W-1:0] rd_data;
  logic [STRB_W-1:0] rd_parity;
  logic              init_complete;

  logic [DATA_W-1:0] ref_mem [NUM_ADDR];           // reference model of the whole map
  logic [DATA_W-1:0] exp_data_q [$];               // reads still in flight
  logic [STRB_W-1:0] exp_par_q  [$];
  logic [ADDR_W-1:0] exp_addr_q [$];
  int                exp_cyc_q  [$];               // negedge count the pulse is due at
  int                cyc;                          // counted at falling edges
  int                errors;
  int                tests_run;
  int                tests_failed;
  logic [31:0]       lcg_state;

  always #(CLK_PERIOD/2) clk = ~clk;

  hbm_ram_top #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .ROWS          (ROWS)
  ) u_hbm_ram_top (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .req_wstrb     (req_wstrb),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .rd_parity     (rd_parity),
    .init_complete (init_complete)
  );

  // 32-bit lcg with numerical recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "hbm_ram_tasks.svh"

  // response monitor samples outputs half a cycle after the edge
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (rd_valid === 1'b1) begin
      if (exp_cyc_q.size() == 0) begin
        $display("rd_valid pulsed at cycle %0d with no read outstanding", cyc);
        errors = errors + 1;
      end else begin
        compare_response();
      end
    end
  end

  // watchdog sized from init time plus the worst case per request
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    req_valid    = 1'b0;
    req_op       = OP_READ;
    req_addr     = '0;
    req_wdata    = '0;
    req_wstrb    = '0;
    cyc          = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lcg_state    = 32'd90;                         // seed
    for (int a = 0; a < NUM_ADDR; a++) begin
      ref_mem[a] = '0;                             // sweep leaves every word cleared
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    init_sweep();
    full_word_writes();
    byte_strobe_writes();
    back_to_back_reads();
    channel_isolation();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/hbm_addr_router.sv
`timescale 1ns/1ps

module hbm_addr_router #(
  parameter int NUM_CHANNELS = 4                    // regions behind the port
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,     // request strobe from the port
  input  hbm_pkg::op_e               req_op,
  input  logic [hbm_pkg::ADDR_W-1:0] req_addr,
  input  logic [hbm_pkg::DATA_W-1:0] req_wdata,
  input  logic [hbm_pkg::STRB_W-1:0] req_wstrb,
  input  logic                       init_complete, // fed back from the merge
  output logic [NUM_CHANNELS-1:0]    chan_valid,    // registered one-hot strobe
  output hbm_pkg::op_e               chan_op,
  output logic [hbm_pkg::ROW_W-1:0]  chan_row,
  output logic [hbm_pkg::DATA_W-1:0] chan_wdata,
  output logic [hbm_pkg::STRB_W-1:0] chan_wstrb
);
  import hbm_pkg::*;

  logic [CHAN_W-1:0]       req_chan;                // region field of the address
  logic                    req_accept;              // strobe that survives the init gate
  logic [NUM_CHANNELS-1:0] dec_onehot;              // decoded region select

  assign req_chan   = req_addr[ADDR_W-1 -: CHAN_W]; // top bits select the region
  assign req_accept = req_valid && init_complete;   // drop anything before the sweep ends

  // region decode, each channel owns one value of the field
  always_comb begin
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      dec_onehot[i] = req_accept && (req_chan == CHAN_W'(i));
    end
  end

  // strobe stage
  always_ff @(posedge clk) begin
    if (rst) begin
      chan_valid <= '0;
    end else begin
      chan_valid <= dec_onehot;                     // at most one bit set
    end
  end

  // payload stage, shared by all regions
  always_ff @(posedge clk) begin
    if (req_accept) begin                           // hold payload when idle
      chan_op    <= req_op;
      chan_row   <= req_addr[ROW_W-1:0];            // row inside the region
      chan_wdata <= req_wdata;
      chan_wstrb <= req_wstrb;
    end
  end

endmodule

//--- verilog/hbm_channel.sv
`timescale 1ns/1ps

module hbm_channel #(
  parameter int ROWS = 16                         // words held by this region
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,   // this region's bit of the router strobe
  input  hbm_pkg::op_e               op,
  input  logic [hbm_pkg::ROW_W-1:0]  row,
  input  logic [hbm_pkg::DATA_W-1:0] wdata,
  input  logic [hbm_pkg::STRB_W-1:0] wstrb,
  output logic                       rd_valid,    // pulse one cycle after a read strobe
  output logic [hbm_pkg::DATA_W-1:0] rd_data,
  output logic [hbm_pkg::STRB_W-1:0] rd_parity,   // parity read back as stored
  output logic                       init_done    // level that stays high once swept
);
  import hbm_pkg::*;

  logic [DATA_W-1:0] mem_data [ROWS];             // payload array
  logic [STRB_W-1:0] mem_par  [ROWS];             // even parity where bit b covers byte b

  chan_state_e       state;
  logic [ROW_W-1:0]  init_row;                    // sweep pointer
  logic              init_last;                   // pointer at the final row

  // write port shared by the sweep and requests
  logic              wr_en;
  logic [ROW_W-1:0]  wr_row;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;
  logic [STRB_W-1:0] wr_par;                      // parity of wr_data per byte
  logic              rd_en;

  assign init_last = (init_row == ROW_W'(ROWS - 1));

  // control FSM clears one row per cycle then idles for good
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_INIT;
      init_row <= '0;
    end else if (state == ST_INIT) begin
      init_row <= init_row + 1'b1;
      if (init_last) begin
        state <= ST_IDLE;                         // last row written this edge
      end
    end
  end

  // the sweep owns the array until it finishes
  always_comb begin
    if (state == ST_INIT) begin
      wr_en   = 1'b1;
      wr_row  = init_row;
      wr_data = '0;                               // zero word gives zero parity
      wr_strb = '1;                               // every lane
    end else begin
      wr_en   = req_valid && (op == OP_WRITE);
      wr_row  = row;
      wr_data = wdata;
      wr_strb = wstrb;
    end
  end

  assign rd_en = req_valid && (op == OP_READ);

  // even parity over each byte lane
  always_comb begin
    for (int b = 0; b < STRB_W; b++) begin
      wr_par[b] = ^wr_data[b*8 +: 8];
    end
  end

  // strobed write leaves untouched lanes with their data and parity
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_strb[b]) begin
          mem_data[wr_row][b*8 +: 8] <= wr_data[b*8 +: 8];
          mem_par[wr_row][b]         <= wr_par[b];
        end
      end
    end
  end

  // read pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // registered read on the same edge as any array write
  // a region sees one request per cycle so read and write never share a row here
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data   <= mem_data[row];
      rd_parity <= mem_par[row];
    end
  end

  assign init_done = (state == ST_IDLE);

endmodule

//--- verilog/hbm_pkg.sv
package hbm_pkg;

  // data path sizes, one memory word per request
  localparam int DATA_W = 256;                  // memory word width
  localparam int STRB_W = DATA_W / 8;           // byte lanes, also parity bits per word

  // address map
  // the upper CHAN_W bits of a word address pick the region
  // and the lower ROW_W bits pick the row inside it
  localparam int CHAN_W = 2;                    // region select bits
  localparam int ROW_W  = 4;                    // row bits per region
  localparam int ADDR_W = CHAN_W + ROW_W;       // full word address

  // read pipeline depth as seen from the top-level port
  // router stage, array read stage and merge stage
  localparam int READ_LATENCY = 3;

  // request opcode carried with every strobe
  typedef enum logic {
    OP_READ  = 1'b0,                            // registered read, answered by rd_valid
    OP_WRITE = 1'b1                             // strobed write, no response
  } op_e;

  // per-channel control state
  typedef enum logic {
    ST_INIT = 1'b0,                             // clearing rows after reset
    ST_IDLE = 1'b1                              // sweep done, serving requests
  } chan_state_e;

endpackage

//--- verilog/hbm_ram_top.sv
`timescale 1ns/1ps

module hbm_ram_top #(
  parameter int NUM_CHANNELS = 4,                  // number of equal regions
  parameter int ROWS         = 16                  // words per region
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,    // one-cycle request strobe
  input  hbm_pkg::op_e               req_op,
  input  logic [hbm_pkg::ADDR_W-1:0] req_addr,     // {channel, row}
  input  logic [hbm_pkg::DATA_W-1:0] req_wdata,
  input  logic [hbm_pkg::STRB_W-1:0] req_wstrb,    // byte enables for writes
  output logic                       rd_valid,     // one-cycle read answer
  output logic [hbm_pkg::DATA_W-1:0] rd_data,
  output logic [hbm_pkg::STRB_W-1:0] rd_parity,    // stored even parity, one bit per byte
  output logic                       init_complete // all regions swept
);
  import hbm_pkg::*;

  // router to channels, payload shared by every region
  logic [NUM_CHANNELS-1:0]        chan_valid;      // one-hot region strobe
  op_e                            chan_op;
  logic [ROW_W-1:0]               chan_row;
  logic [DATA_W-1:0]              chan_wdata;
  logic [STRB_W-1:0]              chan_wstrb;

  // channels to merge, packed per region
  logic [NUM_CHANNELS-1:0]        ch_rd_valid;
  logic [NUM_CHANNELS*DATA_W-1:0] ch_rd_data;
  logic [NUM_CHANNELS*STRB_W-1:0] ch_rd_parity;
  logic [NUM_CHANNELS-1:0]        ch_init_done;

  hbm_addr_router #(
    .NUM_CHANNELS  (NUM_CHANNELS)
  ) u_addr_router (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .req_wstrb     (req_wstrb),
    .init_complete (init_complete),                // requests held off until swept
    .chan_valid    (chan_valid),
    .chan_op       (chan_op),
    .chan_row      (chan_row),
    .chan_wdata    (chan_wdata),
    .chan_wstrb    (chan_wstrb)
  );

  // one region per channel, index set by position in the loop
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    hbm_channel #(
      .ROWS      (ROWS)
    ) u_channel (
      .clk       (clk),
      .rst       (rst),
      .req_valid (chan_valid[i]),
      .op        (chan_op),
      .row       (chan_row),
      .wdata     (chan_wdata),
      .wstrb     (chan_wstrb),
      .rd_valid  (ch_rd_valid[i]),
      .rd_data   (ch_rd_data[i*DATA_W +: DATA_W]),
      .rd_parity (ch_rd_parity[i*STRB_W +: STRB_W]),
      .init_done (ch_init_done[i])
    );
  end

  hbm_read_merge #(
    .NUM_CHANNELS  (NUM_CHANNELS)
  ) u_read_merge (
    .clk           (clk),
    .rst           (rst),
    .ch_rd_valid   (ch_rd_valid),
    .ch_rd_data    (ch_rd_data),
    .ch_rd_parity  (ch_rd_parity),
    .ch_init_done  (ch_init_done),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .rd_parity     (rd_parity),
    .init_complete (init_complete)
  );

endmodule

//--- verilog/hbm_read_merge.sv
`timescale 1ns/1ps

module hbm_read_merge #(
  parameter int NUM_CHANNELS = 4                            // regions feeding the merge
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [NUM_CHANNELS-1:0]                 ch_rd_valid,  // at most one set per cycle
  input  logic [NUM_CHANNELS*hbm_pkg::DATA_W-1:0] ch_rd_data,
  input  logic [NUM_CHANNELS*hbm_pkg::STRB_W-1:0] ch_rd_parity,
  input  logic [NUM_CHANNELS-1:0]                 ch_init_done,
  output logic                                    rd_valid,
  output logic [hbm_pkg::DATA_W-1:0]              rd_data,
  output logic [hbm_pkg::STRB_W-1:0]              rd_parity,
  output logic                                    init_complete // back to the router too
);
  import hbm_pkg::*;

  logic              any_valid;                              // some region answered
  logic [DATA_W-1:0] sel_data;
  logic [STRB_W-1:0] sel_parity;

  assign any_valid = |ch_rd_valid;

  // and-or select, the router only ever strobes one region
  always_comb begin
    sel_data   = '0;
    sel_parity = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      sel_data   = sel_data   | ({DATA_W{ch_rd_valid[i]}} & ch_rd_data[i*DATA_W +: DATA_W]);
      sel_parity = sel_parity | ({STRB_W{ch_rd_valid[i]}} & ch_rd_parity[i*STRB_W +: STRB_W]);
    end
  end

  // control stage
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid      <= 1'b0;
      init_complete <= 1'b0;
    end else begin
      rd_valid      <= any_valid;
      init_complete <= &ch_init_done;                        // slowest region decides
    end
  end

  // payload stage
  always_ff @(posedge clk) begin
    if (any_valid) begin                                     // hold last answer between reads
      rd_data   <= sel_data;
      rd_parity <= sel_parity;
    end
  end

endmodule
